/* src/scan_config.svh */
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// Stream space and field widths
`define SCAN_STREAMS 64
`define SCAN_ID_W 6
`define SCAN_STATE_W 3
`define SCAN_COUNT_W 16

// Keyword "PASS", upper case letters
`define SCAN_KEY_LEN 4
`define SCAN_KEY0 8'h50
`define SCAN_KEY1 8'h41
`define SCAN_KEY2 8'h53
`define SCAN_KEY3 8'h53

`endif

/* src/scan_pkg.sv */
`default_nettype none

`include "scan_config.svh"

package scan_pkg;

   // Input beat kinds
   typedef enum logic [1:0] {
      BEAT_IDLE,
      BEAT_SOP,
      BEAT_DATA,
      BEAT_EOP
   } beat_op_e;

   // One input beat, valid whenever op is not idle
   typedef struct packed {
      beat_op_e               op;
      logic                   enable;
      logic [`SCAN_ID_W-1:0]  stream_id;
      logic [7:0]             data;
   } scan_beat_t;

   // Matcher commands produced by the decoder
   typedef enum logic [2:0] {
      CMD_NONE,
      CMD_RESTORE,
      CMD_FRESH,
      CMD_CHAR,
      CMD_COMMIT,
      CMD_DISCARD
   } cmd_op_e;

   typedef struct packed {
      cmd_op_e                op;
      logic [`SCAN_ID_W-1:0]  stream_id;
      logic [7:0]             data;
   } scan_cmd_t;

   // Per-packet result record
   typedef struct packed {
      logic [`SCAN_ID_W-1:0]     stream_id;
      logic                      enabled;
      logic                      matched;
      logic [`SCAN_COUNT_W-1:0]  count;
   } scan_result_t;

endpackage

`default_nettype wire

/* src/beat_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_config.svh"

module beat_decode (
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire scan_pkg::scan_beat_t beat,
   output scan_pkg::scan_cmd_t   cmd
);

   // One bit per stream, set once an enabled packet has saved state
   logic [`SCAN_STREAMS-1:0] seen_q;

   // Packet currently open on the input
   logic [`SCAN_ID_W-1:0]    pkt_id_q;
   logic                     pkt_en_q;

   // Next command fields
   scan_pkg::cmd_op_e        op_d;
   logic [`SCAN_ID_W-1:0]    id_d;

   // Registered command fields
   scan_pkg::cmd_op_e        op_q;
   logic [`SCAN_ID_W-1:0]    id_q;
   logic [7:0]               data_q;

   always_comb
   begin
      op_d = scan_pkg::CMD_NONE;
      // Data and end beats belong to the open packet
      id_d = pkt_id_q;
      case (beat.op)
         scan_pkg::BEAT_SOP:
         begin
            // Known streams pick up where they left off
            op_d = seen_q[beat.stream_id] ? scan_pkg::CMD_RESTORE : scan_pkg::CMD_FRESH;
            id_d = beat.stream_id;
         end
         scan_pkg::BEAT_DATA:
            op_d = scan_pkg::CMD_CHAR;
         scan_pkg::BEAT_EOP:
            // Disabled packets leave no trace in the context memory
            op_d = pkt_en_q ? scan_pkg::CMD_COMMIT : scan_pkg::CMD_DISCARD;
         default:
            op_d = scan_pkg::CMD_NONE;
      endcase
   end

   // Control state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         op_q     <= scan_pkg::CMD_NONE;
         seen_q   <= '0;
         pkt_en_q <= 1'b0;
      end
      else
      begin
         op_q <= op_d;
         if (beat.op == scan_pkg::BEAT_SOP)
            pkt_en_q <= beat.enable;
         // Stream has a valid saved entry from now on
         if (op_d == scan_pkg::CMD_COMMIT)
            seen_q[pkt_id_q] <= 1'b1;
      end
   end

   // Payload
   always_ff @(posedge clk)
   begin
      id_q   <= id_d;
      data_q <= beat.data;
      if (beat.op == scan_pkg::BEAT_SOP)
         pkt_id_q <= beat.stream_id;
   end

   assign cmd = '{op: op_q, stream_id: id_q, data: data_q};

endmodule

`default_nettype wire

/* src/keyword_dfa.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_config.svh"

module keyword_dfa (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire scan_pkg::scan_cmd_t cmd,
   input  wire [`SCAN_STATE_W-1:0]  restore_state,
   input  wire                      restore_load,
   output logic [`SCAN_STATE_W-1:0] dfa_state,
   output logic                     accept
);

   // Last position before the keyword completes
   localparam logic [`SCAN_STATE_W-1:0] LAST_POS = `SCAN_STATE_W'(`SCAN_KEY_LEN - 1);

   logic [`SCAN_STATE_W-1:0] state_d;
   logic                     accept_d;
   logic [7:0]               char_up;

   // Keyword letter expected at a given match position
   function automatic logic [7:0] key_char(input logic [`SCAN_STATE_W-1:0] pos);
      case (pos)
         3'd0:    key_char = `SCAN_KEY0;
         3'd1:    key_char = `SCAN_KEY1;
         3'd2:    key_char = `SCAN_KEY2;
         default: key_char = `SCAN_KEY3;
      endcase
   endfunction

   // Fold lower case letters onto upper case
   assign char_up = ((cmd.data >= 8'h61) && (cmd.data <= 8'h7a)) ? cmd.data - 8'h20 : cmd.data;

   always_comb
   begin
      state_d  = dfa_state;
      accept_d = 1'b0;
      if (restore_load)
         state_d = restore_state;
      else if (cmd.op == scan_pkg::CMD_CHAR)
      begin
         if (char_up == key_char(dfa_state))
         begin
            // Full keyword seen, start over
            if (dfa_state == LAST_POS)
            begin
               state_d  = '0;
               accept_d = 1'b1;
            end
            else
               state_d = dfa_state + 1'b1;
         end
         // First letter occurs only once, so a mismatch falls back to 0 or 1
         else if (char_up == `SCAN_KEY0)
            state_d = `SCAN_STATE_W'(1);
         else
            state_d = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         dfa_state <= '0;
         accept    <= 1'b0;
      end
      else
      begin
         dfa_state <= state_d;
         accept    <= accept_d;
      end
   end

endmodule

`default_nettype wire

/* src/stream_context.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_config.svh"

module stream_context (
   input  wire                      clk,
   input  wire scan_pkg::scan_cmd_t cmd,
   input  wire [`SCAN_STATE_W-1:0]  dfa_state,
   output logic [`SCAN_STATE_W-1:0] restore_state,
   output logic                     restore_load
);

   // Saved matcher state, one entry per stream
   logic [`SCAN_STATE_W-1:0] state_mem [`SCAN_STREAMS];

   logic is_restore;
   logic is_fresh;
   logic is_commit;

   assign is_restore = (cmd.op == scan_pkg::CMD_RESTORE);
   assign is_fresh   = (cmd.op == scan_pkg::CMD_FRESH);
   assign is_commit  = (cmd.op == scan_pkg::CMD_COMMIT);

   // Matcher reloads at every packet start
   assign restore_load = is_restore | is_fresh;

   // Stored entry for a known stream, clean state otherwise
   always_comb
   begin
      if (is_restore)
         restore_state = state_mem[cmd.stream_id];
      else
         restore_state = '0;
   end

   // Matcher state after the last char is the value to keep
   always_ff @(posedge clk)
   begin
      if (is_commit)
         state_mem[cmd.stream_id] <= dfa_state;
   end

endmodule

`default_nettype wire

/* src/match_tally.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_config.svh"

module match_tally (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire scan_pkg::scan_cmd_t    cmd,
   input  wire                         accept,
   output scan_pkg::scan_result_t      result,
   output logic                        result_valid
);

   // Match seen somewhere in the open packet
   logic                     flag_q;
   logic                     hit;
   logic [`SCAN_COUNT_W-1:0] count_q;
   logic [`SCAN_COUNT_W-1:0] count_inc;
   logic                     pkt_start;
   logic                     pkt_end;

   assign pkt_start = (cmd.op == scan_pkg::CMD_FRESH) || (cmd.op == scan_pkg::CMD_RESTORE);
   assign pkt_end   = (cmd.op == scan_pkg::CMD_COMMIT) || (cmd.op == scan_pkg::CMD_DISCARD);

   // Accept of the last char lines up with the end command
   assign hit       = flag_q | accept;
   assign count_inc = count_q + {{(`SCAN_COUNT_W-1){1'b0}}, hit};

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         flag_q       <= 1'b0;
         count_q      <= '0;
         result_valid <= 1'b0;
      end
      else
      begin
         if (pkt_start)
            flag_q <= 1'b0;
         else if (accept)
            flag_q <= 1'b1;
         // Only enabled packets are counted
         if (cmd.op == scan_pkg::CMD_COMMIT)
            count_q <= count_inc;
         result_valid <= pkt_end;
      end
   end

   // Result record, one per packet
   always_ff @(posedge clk)
   begin
      if (pkt_end)
      begin
         result.stream_id <= cmd.stream_id;
         result.enabled   <= (cmd.op == scan_pkg::CMD_COMMIT);
         result.matched   <= (cmd.op == scan_pkg::CMD_COMMIT) && hit;
         result.count     <= (cmd.op == scan_pkg::CMD_COMMIT) ? count_inc : count_q;
      end
   end

endmodule

`default_nettype wire

/* src/packet_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_config.svh"

module packet_scanner (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire scan_pkg::scan_beat_t  beat,
   output scan_pkg::scan_result_t     result,
   output logic                       result_valid
);

   // Decoded command shared by all stages
   scan_pkg::scan_cmd_t      cmd;

   // Context save and restore loop
   logic [`SCAN_STATE_W-1:0] restore_state;
   logic                     restore_load;
   logic [`SCAN_STATE_W-1:0] dfa_state;
   logic                     accept;

   beat_decode u_beat_decode (
      .clk  (clk),
      .rst_n(rst_n),
      .beat (beat),
      .cmd  (cmd)
   );

   stream_context u_stream_context (
      .clk          (clk),
      .cmd          (cmd),
      .dfa_state    (dfa_state),
      .restore_state(restore_state),
      .restore_load (restore_load)
   );

   keyword_dfa u_keyword_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd          (cmd),
      .restore_state(restore_state),
      .restore_load (restore_load),
      .dfa_state    (dfa_state),
      .accept       (accept)
   );

   // Result lands two cycles after the end beat
   match_tally u_match_tally (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd         (cmd),
      .accept      (accept),
      .result      (result),
      .result_valid(result_valid)
   );

endmodule

`default_nettype wire

/* testbench/tb_packet_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scan_config.svh"

module tb_packet_scanner;

   logic                   clk = 1'b0;
   logic                   rst_n;
   scan_pkg::scan_beat_t   beat;
   scan_pkg::scan_result_t result;
   logic                   result_valid;

   // Reference model of the keyword rule and the per-stream context
   byte unsigned keyword [`SCAN_KEY_LEN];
   int           saved [`SCAN_STREAMS];
   bit           seen [`SCAN_STREAMS];
   int           exp_count;
   integer       seed;
   string        alphabet = "PASpasx";
   byte unsigned pkt_bytes [$];
   scan_pkg::scan_result_t last_result;

   // 4 ns clock
   always #2 clk = ~clk;

   packet_scanner u_packet_scanner (
      .clk         (clk),
      .rst_n       (rst_n),
      .beat        (beat),
      .result      (result),
      .result_valid(result_valid)
   );

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1);
      end
   endtask

   // Next matcher position for one byte, hit set when the keyword completes
   function automatic int model_step(input int st, input byte unsigned ch, output bit hit);
      byte unsigned up;
      up  = (ch >= "a" && ch <= "z") ? ch - 8'h20 : ch;
      hit = 1'b0;
      if (up == keyword[st])
      begin
         if (st == `SCAN_KEY_LEN - 1)
         begin
            hit = 1'b1;
            return 0;
         end
         return st + 1;
      end
      // Keyword letter 0 is unique, so it alone restarts a partial match
      return (up == keyword[0]) ? 1 : 0;
   endfunction

   // One beat, driven just after the rising edge
   task automatic drive_beat(input scan_pkg::beat_op_e op, input bit en, input int id,
                             input byte unsigned data);
      @(posedge clk);
      #1;
      beat.op        = op;
      beat.enable    = en;
      beat.stream_id = `SCAN_ID_W'(id);
      beat.data      = data;
   endtask

   task automatic load_text(input string text);
      pkt_bytes.delete();
      for (int i = 0; i < text.len(); i++)
         pkt_bytes.push_back(text[i]);
   endtask

   // Sends pkt_bytes as one packet and checks its result against the model
   task automatic send_packet(input int id, input bit en);
      int st;
      int waited;
      bit hit;
      bit exp_match;
      st        = seen[id] ? saved[id] : 0;
      exp_match = 1'b0;
      drive_beat(scan_pkg::BEAT_SOP, en, id, 8'h00);
      // Only the start beat carries the stream id and enable
      foreach (pkt_bytes[i])
      begin
         drive_beat(scan_pkg::BEAT_DATA, 1'b0, 0, pkt_bytes[i]);
         st        = model_step(st, pkt_bytes[i], hit);
         exp_match = exp_match | hit;
      end
      drive_beat(scan_pkg::BEAT_EOP, 1'b0, 0, 8'h00);
      drive_beat(scan_pkg::BEAT_IDLE, 1'b0, 0, 8'h00);
      waited = 1;
      // Only an enabled packet is counted and keeps its end state
      if (en)
      begin
         exp_count = exp_count + exp_match;
         saved[id] = st;
         seen[id]  = 1'b1;
      end
      else
         exp_match = 1'b0;
      while (result_valid !== 1'b1)
      begin
         if (waited >= 10)
         begin
            $display("Timeout: no result for the packet on stream %0d", id);
            $display("SIMULATION FAILED");
            $fatal(1);
         end
         @(posedge clk);
         #1;
         waited++;
      end
      // Result is due two cycles after the end beat
      check_value("result latency", waited, 2);
      check_value("result.stream_id", result.stream_id, id);
      check_value("result.enabled", result.enabled, en);
      check_value("result.matched", result.matched, exp_match);
      check_value("result.count", result.count, exp_count);
      last_result = result;
      @(posedge clk);
      #1;
      check_value("result_valid", result_valid, 1'b0);
   endtask

   task automatic test_reset_idle();
      for (int i = 0; i < 8; i++)
      begin
         @(posedge clk);
         #1;
         check_value("result_valid", result_valid, 1'b0);
      end
      load_text("PASS");
      send_packet(1, 1'b1);
      check_value("result.count", last_result.count, 1);
   endtask

   task automatic test_case_and_fallback();
      logic [`SCAN_COUNT_W-1:0] prev;
      prev = last_result.count;
      load_text("xxpAsSyy");
      send_packet(2, 1'b1);
      check_value("result.matched", last_result.matched, 1'b1);
      check_value("result.count", last_result.count, prev + 1);
      // PA then PAS then X, never a full keyword
      load_text("PAPASX");
      send_packet(3, 1'b1);
      check_value("result.matched", last_result.matched, 1'b0);
   endtask

   task automatic test_split_keyword();
      load_text("..PA");
      send_packet(5, 1'b1);
      check_value("result.matched", last_result.matched, 1'b0);
      load_text("SS..");
      send_packet(5, 1'b1);
      check_value("result.matched", last_result.matched, 1'b1);
   endtask

   task automatic test_fresh_stream();
      load_text("PA");
      send_packet(9, 1'b1);
      load_text("SS");
      send_packet(12, 1'b1);
      check_value("result.matched", last_result.matched, 1'b0);
   endtask

   task automatic test_disabled_packet();
      logic [`SCAN_COUNT_W-1:0] prev;
      prev = last_result.count;
      // Full keyword, then a partial match left open at the end
      load_text("PASSPA");
      send_packet(20, 1'b0);
      check_value("result.enabled", last_result.enabled, 1'b0);
      check_value("result.matched", last_result.matched, 1'b0);
      check_value("result.count", last_result.count, prev);
      // Nothing was saved, so SS alone cannot finish a keyword
      load_text("SS..");
      send_packet(20, 1'b1);
      check_value("result.matched", last_result.matched, 1'b0);
   endtask

   task automatic test_random_packets();
      int id;
      int len;
      bit en;
      for (int n = 0; n < 40; n++)
      begin
         id  = 40 + ($unsigned($random(seed)) % 8);
         en  = $random(seed) & 1;
         len = 1 + ($unsigned($random(seed)) % 8);
         pkt_bytes.delete();
         for (int k = 0; k < len; k++)
            pkt_bytes.push_back(alphabet[$unsigned($random(seed)) % 7]);
         send_packet(id, en);
      end
   endtask

   initial
   begin
      seed       = 32'hb2a1_16ce;
      keyword[0] = `SCAN_KEY0;
      keyword[1] = `SCAN_KEY1;
      keyword[2] = `SCAN_KEY2;
      keyword[3] = `SCAN_KEY3;
      exp_count  = 0;
      beat       = '0;
      rst_n      = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      test_reset_idle();
      test_case_and_fallback();
      test_split_keyword();
      test_fresh_stream();
      test_disabled_packet();
      test_random_packets();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/scan_pkg.sv
src/beat_decode.sv
src/keyword_dfa.sv
src/stream_context.sv
src/match_tally.sv
src/packet_scanner.sv
testbench/tb_packet_scanner.sv

/* Bender.yml */
package:
  name: packet_scanner

sources:
  - include_dirs:
      - src
    files:
      - src/scan_pkg.sv
      - src/beat_decode.sv
      - src/keyword_dfa.sv
      - src/stream_context.sv
      - src/match_tally.sv
      - src/packet_scanner.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_packet_scanner.sv
